// File: verilog/regAddrPkg.sv
// Register storage types shared by the pair bank, read port and testbench model
`default_nettype none

package regAddrPkg;

    // Byte view of a pair, high byte first as on the bus
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } regBytesT;

    // One 16-bit pair seen either as a word or as two bytes
    typedef union packed {
        logic [15:0] word;
        regBytesT    bytes;
    } regPairT;

    // Byte select on the read port
    localparam logic BYTE_LO = 1'b0;
    localparam logic BYTE_HI = 1'b1;

endpackage

`default_nettype wire

// File: verilog/regOpPkg.sv
// Command encodings for the register-pair block, used by the decoder, top level and testbench
`default_nettype none

package regOpPkg;

    localparam int OP_WIDTH = 3;

    typedef enum logic [OP_WIDTH-1:0] {
        OP_NOP    = 3'd0,
        OP_LOAD16 = 3'd1,   // Whole pair
        OP_LOADHI = 3'd2,   // High byte only
        OP_LOADLO = 3'd3,   // Low byte only
        OP_INC    = 3'd4,
        OP_DEC    = 3'd5
    } regOpT;

endpackage

`default_nettype wire

// File: verilog/regIncDec16.sv
// Ripple increment/decrement of one 16-bit pair, half-adder stages with internal complement
`timescale 1ns/1ps
`default_nettype none

module regIncDec16 (
    input  logic [15:0] opIn,
    input  logic        dec,
    output logic [15:0] opOut
);

    localparam int WIDTH = 16;

    logic [WIDTH-1:0] notIn;
    logic [WIDTH-1:0] stageIn;  // True form for increment, complement for decrement
    logic [WIDTH:0]   carry;    // Carry, or borrow when decrementing

    assign notIn    = ~opIn;
    assign carry[0] = 1'b1;     // Always adding or taking one

    // Each stage is a half adder on its bit and the incoming carry
    // Increment carries through ones, decrement borrows through zeros
    genvar i;
    generate
        for (i = 0; i < WIDTH; i++) begin : gStage
            assign stageIn[i]   = dec ? notIn[i] : opIn[i];
            assign opOut[i]     = opIn[i] ^ carry[i];
            assign carry[i + 1] = stageIn[i] & carry[i];
        end
    endgenerate

    // carry[WIDTH] is the wrap out of bit 15, dropped for modulo 2^16

endmodule

`default_nettype wire

// File: verilog/regCmdDecode.sv
// Command input stage; registers a strobed command and decodes it into bank write enables
`timescale 1ns/1ps
`default_nettype none

module regCmdDecode #(
    parameter int NUM_PAIRS = 4
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         cmdValid,
    input  regOpPkg::regOpT              cmdOp,
    input  logic [$clog2(NUM_PAIRS)-1:0] cmdPair,
    input  logic [15:0]                  cmdData,
    output logic                         wrHi,
    output logic                         wrLo,
    output logic                         arithEn,
    output logic                         arithDec,
    output logic [$clog2(NUM_PAIRS)-1:0] exPair,
    output logic [15:0]                  exData
);

    import regOpPkg::*;

    // Enables last one cycle per accepted command
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrHi     <= 1'b0;
            wrLo     <= 1'b0;
            arithEn  <= 1'b0;
            arithDec <= 1'b0;
        end else begin
            wrHi     <= 1'b0;
            wrLo     <= 1'b0;
            arithEn  <= 1'b0;
            arithDec <= 1'b0;
            if (cmdValid) begin
                case (cmdOp)
                    OP_LOAD16: begin
                        wrHi <= 1'b1;
                        wrLo <= 1'b1;
                    end
                    OP_LOADHI: wrHi <= 1'b1;
                    OP_LOADLO: wrLo <= 1'b1;
                    OP_INC:    arithEn <= 1'b1;
                    OP_DEC: begin
                        arithEn  <= 1'b1;
                        arithDec <= 1'b1;
                    end
                    default: ;  // NOP and unused codes
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmdValid) begin
            exPair <= cmdPair;
            exData <= cmdData;
        end
    end

endmodule

`default_nettype wire

// File: verilog/regPairBank.sv
// Register pair storage; applies decoded byte writes and inc/dec results, pulses zeroFlag
`timescale 1ns/1ps
`default_nettype none

module regPairBank #(
    parameter int NUM_PAIRS = 4
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         wrHi,
    input  logic                         wrLo,
    input  logic                         arithEn,
    input  logic                         arithDec,
    input  logic [$clog2(NUM_PAIRS)-1:0] exPair,
    input  logic [15:0]                  exData,
    output logic [NUM_PAIRS*16-1:0]      pairsFlat,
    output logic                         zeroFlag
);

    import regAddrPkg::*;

    regPairT     pairs [NUM_PAIRS];
    regPairT     exView;        // Command data split into bytes
    logic [15:0] opIn;
    logic [15:0] opOut;

    assign exView = exData;
    assign opIn   = pairs[exPair].word;    // Current value, so back-to-back ops chain

    regIncDec16 incDec_i (
        .opIn  (opIn),
        .dec   (arithDec),
        .opOut (opOut)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int p = 0; p < NUM_PAIRS; p++) begin
                pairs[p] <= '0;
            end
        end else if (arithEn) begin
            pairs[exPair].word <= opOut;
        end else begin
            if (wrHi) begin
                pairs[exPair].bytes.hi <= exView.bytes.hi;
            end
            if (wrLo) begin
                pairs[exPair].bytes.lo <= exView.bytes.lo;
            end
        end
    end

    // Loop counter hit zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            zeroFlag <= 1'b0;
        end else begin
            zeroFlag <= arithEn && (opOut == 16'h0000);
        end
    end

    genvar g;
    generate
        for (g = 0; g < NUM_PAIRS; g++) begin : gFlat
            assign pairsFlat[g*16 +: 16] = pairs[g].word;
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/regReadPort.sv
// Registered read port; returns the selected pair as a word and one chosen byte of it
`timescale 1ns/1ps
`default_nettype none

module regReadPort #(
    parameter int NUM_PAIRS = 4
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [NUM_PAIRS*16-1:0]      pairsFlat,
    input  logic [$clog2(NUM_PAIRS)-1:0] rdPair,
    input  logic                         rdByteSel,
    output logic [15:0]                  rdWord,
    output logic [7:0]                   rdByte
);

    import regAddrPkg::*;

    regPairT    selPair;
    logic [7:0] selByte;

    assign selPair = pairsFlat[rdPair*16 +: 16];

    always_comb begin
        case (rdByteSel)
            BYTE_HI: selByte = selPair.bytes.hi;
            BYTE_LO: selByte = selPair.bytes.lo;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdWord <= 16'h0000;
            rdByte <= 8'h00;
        end else begin
            rdWord <= selPair.word;
            rdByte <= selByte;
        end
    end

endmodule

`default_nettype wire

// File: verilog/regFileTop.sv
// Top level of the register-pair block; sets the pair count and wires decode, bank and read port
`timescale 1ns/1ps
`default_nettype none

module regFileTop #(
    parameter int NUM_PAIRS = 4
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         cmdValid,
    input  regOpPkg::regOpT              cmdOp,
    input  logic [$clog2(NUM_PAIRS)-1:0] cmdPair,
    input  logic [15:0]                  cmdData,
    input  logic [$clog2(NUM_PAIRS)-1:0] rdPair,
    input  logic                         rdByteSel,
    output logic [15:0]                  rdWord,
    output logic [7:0]                   rdByte,
    output logic                         zeroFlag
);

    logic                         wrHi;
    logic                         wrLo;
    logic                         arithEn;
    logic                         arithDec;
    logic [$clog2(NUM_PAIRS)-1:0] exPair;
    logic [15:0]                  exData;
    logic [NUM_PAIRS*16-1:0]      pairsFlat;

    regCmdDecode #(.NUM_PAIRS(NUM_PAIRS)) cmdDecode_i (
        .clk      (clk),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmdOp    (cmdOp),
        .cmdPair  (cmdPair),
        .cmdData  (cmdData),
        .wrHi     (wrHi),
        .wrLo     (wrLo),
        .arithEn  (arithEn),
        .arithDec (arithDec),
        .exPair   (exPair),
        .exData   (exData)
    );

    regPairBank #(.NUM_PAIRS(NUM_PAIRS)) pairBank_i (
        .clk       (clk),
        .rstN      (rstN),
        .wrHi      (wrHi),
        .wrLo      (wrLo),
        .arithEn   (arithEn),
        .arithDec  (arithDec),
        .exPair    (exPair),
        .exData    (exData),
        .pairsFlat (pairsFlat),
        .zeroFlag  (zeroFlag)
    );

    regReadPort #(.NUM_PAIRS(NUM_PAIRS)) readPort_i (
        .clk       (clk),
        .rstN      (rstN),
        .pairsFlat (pairsFlat),
        .rdPair    (rdPair),
        .rdByteSel (rdByteSel),
        .rdWord    (rdWord),
        .rdByte    (rdByte)
    );

endmodule

`default_nettype wire

// File: testbench/regFile_assert.sv
// Concurrent checks bound into the pair bank; zero pulse origin and length, write isolation
`timescale 1ns/1ps
`default_nettype none

module pairBankChecks #(
    parameter int NUM_PAIRS = 4
) (
    input logic                         clk,
    input logic                         rstN,
    input logic                         wrHi,
    input logic                         wrLo,
    input logic                         arithEn,
    input logic [$clog2(NUM_PAIRS)-1:0] exPair,
    input logic [NUM_PAIRS*16-1:0]      pairsFlat,
    input logic                         zeroFlag
);

    localparam int PW = $clog2(NUM_PAIRS);

    logic anyWrite;

    assign anyWrite = wrHi || wrLo || arithEn;

    // The pulse must come from inc/dec, and the pair it wrote must now hold zero
    zeroNeedsArith: assert property (@(posedge clk) disable iff (!rstN)
        zeroFlag |-> ($past(arithEn) && pairsFlat[$past(exPair)*16 +: 16] == 16'h0000))
        else $error("zeroFlag high without an inc/dec that left its pair at zero");

    // A second high cycle needs another zero result, which one pair cannot give twice in a row
    zeroSingleCycle: assert property (@(posedge clk) disable iff (!rstN)
        zeroFlag |=> (!zeroFlag || ($past(arithEn) && $past(exPair) != $past(exPair, 2))))
        else $error("zeroFlag stayed high without a new zero result");

    genvar g;
    generate
        for (g = 0; g < NUM_PAIRS; g++) begin : gIsolate
            localparam logic [PW-1:0] PAIR_ID = PW'(g);

            pairHolds: assert property (@(posedge clk) disable iff (!rstN)
                (!anyWrite || exPair != PAIR_ID) |=> $stable(pairsFlat[g*16 +: 16]))
                else $error("Pair %0d changed although it was not the written pair", g);
        end
    endgenerate

endmodule

bind regPairBank pairBankChecks #(.NUM_PAIRS(NUM_PAIRS)) bankChecks_i (
    .clk       (clk),
    .rstN      (rstN),
    .wrHi      (wrHi),
    .wrLo      (wrLo),
    .arithEn   (arithEn),
    .exPair    (exPair),
    .pairsFlat (pairsFlat),
    .zeroFlag  (zeroFlag)
);

`default_nettype wire

// File: testbench/regFileTb.sv
// Testbench for regFileTop; directed and LCG commands checked against a two-stage model
`timescale 1ns/1ps
`default_nettype none

module regFileTb;

    import regAddrPkg::*;
    import regOpPkg::*;

    localparam int NUM_PAIRS       = 4;
    localparam int PW              = $clog2(NUM_PAIRS);
    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 120;
    localparam int NUM_RAND        = 300;
    localparam int TIMEOUT_NS      =
        (RESET_CYCLES + DIRECTED_CYCLES + 2 * NUM_RAND) * CLK_PERIOD + 1000;

    logic          clk;
    logic          rstN;
    logic          cmdValid;
    regOpT         cmdOp;
    logic [PW-1:0] cmdPair;
    logic [15:0]   cmdData;
    logic [PW-1:0] rdPair;
    logic          rdByteSel;
    logic [15:0]   rdWord;
    logic [7:0]    rdByte;
    logic          zeroFlag;

    regPairT       modelPairs [NUM_PAIRS];
    logic          s1Valid;     // Command as held by the decoder
    regOpT         s1Op;
    logic [PW-1:0] s1Pair;
    logic [15:0]   s1Data;
    logic [15:0]   expWord;
    logic [7:0]    expByte;
    logic          expZero;
    logic [31:0]   lcgState;
    int            errorCount;
    int            checkCount;
    int            zeroPulses;

    regFileTop #(.NUM_PAIRS(NUM_PAIRS)) regFileTop_i (
        .clk       (clk),
        .rstN      (rstN),
        .cmdValid  (cmdValid),
        .cmdOp     (cmdOp),
        .cmdPair   (cmdPair),
        .cmdData   (cmdData),
        .rdPair    (rdPair),
        .rdByteSel (rdByteSel),
        .rdWord    (rdWord),
        .rdByte    (rdByte),
        .zeroFlag  (zeroFlag)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:16];
    endfunction

    function automatic logic [15:0] stepValue(input logic [15:0] v, input logic down);
        return down ? v - 16'd1 : v + 16'd1;    // Wraps modulo 2^16
    endfunction

    // Reference model, one edge to the decoder and one more to the bank
    always @(posedge clk) begin
        if (!rstN) begin
            for (int p = 0; p < NUM_PAIRS; p++) begin
                modelPairs[p] <= '0;
            end
            s1Valid <= 1'b0;
            expWord <= 16'h0000;
            expByte <= 8'h00;
            expZero <= 1'b0;
        end else begin
            s1Valid <= cmdValid;
            s1Op    <= cmdOp;
            s1Pair  <= cmdPair;
            s1Data  <= cmdData;
            expZero <= 1'b0;
            if (s1Valid) begin
                case (s1Op)
                    OP_LOAD16: modelPairs[s1Pair].word <= s1Data;
                    OP_LOADHI: modelPairs[s1Pair].bytes.hi <= s1Data[15:8];
                    OP_LOADLO: modelPairs[s1Pair].bytes.lo <= s1Data[7:0];
                    OP_INC, OP_DEC: begin
                        modelPairs[s1Pair].word <=
                            stepValue(modelPairs[s1Pair].word, s1Op == OP_DEC);
                        expZero <= stepValue(modelPairs[s1Pair].word, s1Op == OP_DEC) == 16'h0;
                    end
                    default: ;
                endcase
            end
            expWord <= modelPairs[rdPair].word;
            expByte <= (rdByteSel == BYTE_HI) ? modelPairs[rdPair].bytes.hi
                                              : modelPairs[rdPair].bytes.lo;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            checkCount++;
            if (zeroFlag) begin
                zeroPulses++;
            end
            assert (rdWord == expWord) else begin
                errorCount++;
                $display("FAILED at %0t: rdWord = %h, expected %h", $time, rdWord, expWord);
            end
            assert (rdByte == expByte) else begin
                errorCount++;
                $display("FAILED at %0t: rdByte = %h, expected %h", $time, rdByte, expByte);
            end
            assert (zeroFlag == expZero) else begin
                errorCount++;
                $display("FAILED at %0t: zeroFlag = %b, expected %b", $time, zeroFlag, expZero);
            end
        end
    end

    task automatic issueCmd(input regOpT op, input logic [PW-1:0] pair, input logic [15:0] data);
        @(posedge clk);
        cmdValid  <= 1'b1;
        cmdOp     <= op;
        cmdPair   <= pair;
        cmdData   <= data;
        rdPair    <= pair;      // Read follows the command
        rdByteSel <= ~rdByteSel;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            cmdValid <= 1'b0;
        end
    endtask

    task automatic sweepReads();
        for (int p = 0; p < NUM_PAIRS; p++) begin
            for (int s = 0; s < 2; s++) begin
                @(posedge clk);
                cmdValid  <= 1'b0;
                rdPair    <= PW'(p);
                rdByteSel <= s[0];
            end
        end
    endtask

    task automatic randomCmd();
        logic [15:0] r;
        logic [15:0] data;
        regOpT       op;
        r = nextRandom();
        case (r % 16'd5)
            16'd0:   op = OP_LOAD16;
            16'd1:   op = OP_LOADHI;
            16'd2:   op = OP_LOADLO;
            16'd3:   op = OP_INC;
            default: op = OP_DEC;
        endcase
        data = nextRandom();
        if (data[3:1] == 3'd0) begin
            data = {15'd0, data[0]};    // Close to zero so dec hits it often
        end else if (data[3:1] == 3'd1) begin
            data = 16'hFFFF;
        end
        issueCmd(op, r[PW+3:4], data);
        if (r[15:13] == 3'd0) begin
            idleCycles(1);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the stimulus finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        cmdValid   = 1'b0;
        cmdOp      = OP_NOP;
        cmdPair    = '0;
        cmdData    = 16'h0000;
        rdPair     = '0;
        rdByteSel  = BYTE_LO;
        lcgState   = 32'd74;
        errorCount = 0;
        checkCount = 0;
        zeroPulses = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;

        sweepReads();                   // All pairs zero after reset
        for (int p = 0; p < NUM_PAIRS; p++) begin
            issueCmd(OP_LOAD16, PW'(p), nextRandom());
        end
        idleCycles(2);
        sweepReads();
        issueCmd(OP_LOADHI, PW'(1), 16'hA55A);
        issueCmd(OP_LOADLO, PW'(2), 16'h5AC3);
        idleCycles(2);
        sweepReads();

        issueCmd(OP_LOAD16, PW'(0), 16'h00FF);
        issueCmd(OP_INC, PW'(0), 16'h0000);     // Carry into the high byte
        issueCmd(OP_LOAD16, PW'(1), 16'hFFFF);
        issueCmd(OP_INC, PW'(1), 16'h0000);     // Wraps to zero
        issueCmd(OP_LOAD16, PW'(2), 16'h0000);
        issueCmd(OP_DEC, PW'(2), 16'h0000);     // Wraps to FFFF
        issueCmd(OP_LOAD16, PW'(3), 16'h0001);
        issueCmd(OP_DEC, PW'(3), 16'h0000);
        issueCmd(OP_DEC, PW'(3), 16'h0000);
        issueCmd(OP_INC, PW'(3), 16'h0000);
        issueCmd(OP_LOAD16, PW'(3), 16'h0000);  // Zero load, no pulse
        idleCycles(2);
        sweepReads();

        for (int i = 0; i < NUM_RAND; i++) begin
            randomCmd();
        end
        idleCycles(2);
        sweepReads();
        idleCycles(3);

        if (zeroPulses == 0) begin
            errorCount++;
            $display("No zeroFlag pulse was seen during the whole run");
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: regFile.f
verilog/regAddrPkg.sv
verilog/regOpPkg.sv
verilog/regIncDec16.sv
verilog/regCmdDecode.sv
verilog/regPairBank.sv
verilog/regReadPort.sv
verilog/regFileTop.sv
testbench/regFile_assert.sv
testbench/regFileTb.sv

// File: Makefile
# Verilator simulation of the register-pair block

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module regFileTb -Mdir obj_dir -f regFile.f
	./obj_dir/VregFileTb > sim.log 2>&1; cat sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "Simulation reported failures"; \
		exit 1; \
	fi
	@grep -q "All tests passed!" sim.log || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log
